/* source/tripleMul_consts.svh */
/*
  format and pipeline constants for the triple-product unit
  reduced float64 layout, no NaN, infinity or subnormal encodings
  pipeline depths must add up to the four-clock latency of the top
*/
`ifndef TRIPLEMUL_CONSTS_SVH
`define TRIPLEMUL_CONSTS_SVH

// word layout, sign on top, then exponent, then stored fraction
`define FP_EXP_WIDTH    11
`define FP_FRACT_WIDTH  52
`define FP_EXP_BIAS     1023

// fraction with the hidden one put back
`define MANT_WIDTH      53

// three 53-bit mantissas multiplied together
`define PROD_WIDTH      159

// operand register in front of decode
`define CAPTURE_DEPTH   1

// sign/exponent/zero sideband, matches the two multiplier stages
`define SIDEBAND_DEPTH  2

`endif

/* source/fpFormatPkg.sv */
/*
  types for the reduced double-precision word
  all-zero exponent and fraction encodes zero, sign is ignored then
  no special values exist, every other word is a normal number
*/
`default_nettype none

`include "tripleMul_consts.svh"

package fpFormatPkg;

  // biased exponent, bias is FP_EXP_BIAS
  typedef logic [`FP_EXP_WIDTH-1:0] fpExpT;

  // stored fraction, hidden leading one not included
  typedef logic [`FP_FRACT_WIDTH-1:0] fpFractT;

  // full 64-bit word as seen on the ports
  typedef struct packed {
    logic    sign;   // 1 = negative
    fpExpT   exp;
    fpFractT fract;
  } fp64T;

endpackage

`default_nettype wire

/* source/mulPipePkg.sv */
/*
  structs passed between the stages of the triple-product pipeline
  the valid bit in the sideband is only trustworthy after the delay line
  has been reset, payload fields carry no reset value
*/
`default_nettype none

`include "tripleMul_consts.svh"

package mulPipePkg;

  import fpFormatPkg::*;

  // a, b and c as captured together with pushin
  typedef struct packed {
    fp64T a;
    fp64T b;
    fp64T c;
  } tripleOperandsT;

  // mantissas with the hidden one restored, decode -> execute
  typedef struct packed {
    logic [`MANT_WIDTH-1:0] a;
    logic [`MANT_WIDTH-1:0] b;
    logic [`MANT_WIDTH-1:0] c;
  } mantTripleT;

  // everything the result stage needs besides the mantissa product
  typedef struct packed {
    logic  valid;  // operation present in this stage
    logic  sign;   // xor of the three operand signs
    fpExpT exp;    // sum of exponents before renormalization
    logic  zero;   // at least one operand was zero
  } fpSidebandT;

  // raw a*b*c, leading one lands somewhere in the top three bits
  typedef logic [`PROD_WIDTH-1:0] mantProductT;

endpackage

`default_nettype wire

/* source/pipeDelay.sv */
/*
  fixed-length delay line carrying a strobe and a payload side by side
  only the strobe bits are reset, payload may hold X until first loaded
  DEPTH below 1 stops elaboration
*/
`timescale 1ns/100ps
`default_nettype none

module pipeDelay #(
  parameter type payloadT = logic,
  parameter int  DEPTH    = 1
) (
  input  logic    clk,
  input  logic    reset,
  input  logic    strobeIn,
  input  payloadT dataIn,
  output logic    strobeOut,
  output payloadT dataOut
);

  logic [DEPTH-1:0] strobePipe;  // one strobe bit per stage
  payloadT          dataPipe [DEPTH];

  // control bits, cleared by reset
  always_ff @(posedge clk) begin
    if (reset) begin
      strobePipe <= '0;
    end else begin
      strobePipe[0] <= strobeIn;
      for (int i = 1; i < DEPTH; i++) begin
        strobePipe[i] <= strobePipe[i-1];
      end
    end
  end

  // payload shifts every cycle, strobe says when it means something
  always_ff @(posedge clk) begin
    dataPipe[0] <= dataIn;
    for (int i = 1; i < DEPTH; i++) begin
      dataPipe[i] <= dataPipe[i-1];
    end
  end

  assign strobeOut = strobePipe[DEPTH-1];
  assign dataOut   = dataPipe[DEPTH-1];

  if (DEPTH < 1) begin : gDepthCheck
    $error("pipeDelay: DEPTH must be at least 1");
  end

endmodule

`default_nettype wire

/* source/mulDecode.sv */
/*
  splits the captured operands into mantissas and sideband fields
  purely combinational, exponent math is modulo 2^11
  results outside the exponent range are not detected
*/
`timescale 1ns/100ps
`default_nettype none

`include "tripleMul_consts.svh"

module mulDecode
  import fpFormatPkg::*;
  import mulPipePkg::*;
(
  input  tripleOperandsT operands,
  input  logic           strobe,
  output mantTripleT     mants,
  output fpSidebandT     sideband
);

  // three biased exponents carry 3*bias, result wants one bias,
  // the +1 places the binary point below product bit 157
  localparam logic [`FP_EXP_WIDTH+1:0] EXP_OFFSET = 2 * `FP_EXP_BIAS - 1;

  logic [`FP_EXP_WIDTH+1:0] expSum;  // two guard bits, sum of three never overflows
  logic                     anyZero;

  // zero is all-zero exponent and fraction, sign bit does not matter
  function automatic logic isZero(input fp64T x);
    return (x.exp == '0) && (x.fract == '0);
  endfunction

  always_comb begin
    // hidden one goes back on top, also for zero words, the result stage masks those
    mants.a = {1'b1, operands.a.fract};
    mants.b = {1'b1, operands.b.fract};
    mants.c = {1'b1, operands.c.fract};
  end

  always_comb begin
    anyZero = isZero(operands.a) || isZero(operands.b) || isZero(operands.c);
    expSum  = {2'b00, operands.a.exp} + {2'b00, operands.b.exp}
            + {2'b00, operands.c.exp} - EXP_OFFSET;
  end

  always_comb begin
    sideband.valid = strobe;
    sideband.sign  = operands.a.sign ^ operands.b.sign ^ operands.c.sign;
    sideband.exp   = expSum[`FP_EXP_WIDTH-1:0];  // wraps, range assumed ok
    sideband.zero  = anyZero;
  end

endmodule

`default_nettype wire

/* source/mantExecute.sv */
/*
  two-stage mantissa multiplier, a*b first, then times c
  no reset and no enable, the sideband strobe qualifies the output
  mantissas must carry their hidden one for the product to be normal
*/
`timescale 1ns/100ps
`default_nettype none

`include "tripleMul_consts.svh"

module mantExecute
  import mulPipePkg::*;
(
  input  logic        clk,
  input  mantTripleT  mants,
  output mantProductT product
);

  logic [2*`MANT_WIDTH-1:0] abProd;     // 106-bit partial product
  logic [`MANT_WIDTH-1:0]   cDelayed;   // c held back one stage to meet abProd
  logic                     hiddenOnes;

  // stage one
  always_ff @(posedge clk) begin
    abProd   <= mants.a * mants.b;
    cDelayed <= mants.c;
  end

  // stage two, widened to the full 159 bits before the multiply
  always_ff @(posedge clk) begin
    product <= abProd * cDelayed;
  end

  assign hiddenOnes = mants.a[`MANT_WIDTH-1] & mants.b[`MANT_WIDTH-1]
                    & mants.c[`MANT_WIDTH-1];

  // each factor lies in [2^52, 2^53), so the product must sit in [2^156, 2^159)
  // two cycles after known normal mantissas went in
  assert property (@(posedge clk)
    $past(hiddenOnes && !$isunknown(mants), 2)
      |-> (product[`PROD_WIDTH-1 -: 3] != 3'b000))
    else $error("mantExecute: product has no leading one in its top three bits");

endmodule

`default_nettype wire

/* source/roundResult.sv */
/*
  round, renormalize and pack the triple product into a float64 word
  rounding is half-up at the bit below the last kept fraction bit
  r only loads on a valid sideband and holds otherwise
  zero operands give +0, never -0
*/
`timescale 1ns/100ps
`default_nettype none

`include "tripleMul_consts.svh"

module roundResult
  import fpFormatPkg::*;
  import mulPipePkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  mantProductT product,
  input  fpSidebandT  sideband,
  output logic        pushout,
  output fp64T        r
);

  localparam int TOP = `PROD_WIDTH - 1;  // bit 158

  mantProductT roundConst;
  mantProductT rounded;
  fpExpT       expOut;
  fpFractT     fractOut;
  fp64T        rNext;

  always_comb begin
    // half an lsb, placed by where the unrounded leading one sits
    roundConst = '0;
    if (product[TOP]) begin
      roundConst[TOP - 1 - `FP_FRACT_WIDTH] = 1'b1;        // bit 105
    end else if (product[TOP - 1]) begin
      roundConst[TOP - 2 - `FP_FRACT_WIDTH] = 1'b1;        // bit 104
    end else begin
      roundConst[TOP - 3 - `FP_FRACT_WIDTH] = 1'b1;        // bit 103
    end
    rounded = product + roundConst;  // cannot overflow 159 bits

    // renormalize on the rounded value, a carry may move the leading one up
    expOut   = sideband.exp;
    fractOut = rounded[TOP - 2 -: `FP_FRACT_WIDTH];        // leading one at 157
    if (rounded[TOP]) begin
      expOut   = sideband.exp + 1'b1;
      fractOut = rounded[TOP - 1 -: `FP_FRACT_WIDTH];
    end else if (!rounded[TOP - 1]) begin
      expOut   = sideband.exp - 1'b1;                      // leading one at 156
      fractOut = rounded[TOP - 3 -: `FP_FRACT_WIDTH];
    end

    if (sideband.zero) begin
      rNext = '0;
    end else begin
      rNext = '{sign: sideband.sign, exp: expOut, fract: fractOut};
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pushout <= 1'b0;
      r       <= '0;
    end else begin
      pushout <= sideband.valid;
      if (sideband.valid) begin
        r <= rNext;  // holds between results
      end
    end
  end

  assert property (@(posedge clk) disable iff (reset) !$isunknown(pushout))
    else $error("roundResult: pushout is unknown");

  // a zero operand seen two stages back must leave as a plain zero word
  assert property (@(posedge clk) disable iff (reset)
    (sideband.valid && sideband.zero) |=> (pushout && (r == '0)))
    else $error("roundResult: zero operand did not give an all-zero result");

endmodule

`default_nettype wire

/* source/tripleMul.sv */
/*
  pipelined r = a*b*c for the reduced float64 format
  result and pushout appear four clocks after pushin, one op per cycle
  no back-pressure, no special values, operands assumed normal or zero
  exponents are assumed to stay in range, no overflow detection
*/
`timescale 1ns/100ps
`default_nettype none

`include "tripleMul_consts.svh"

module tripleMul
  import fpFormatPkg::*;
  import mulPipePkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic pushin,
  input  fp64T a,
  input  fp64T b,
  input  fp64T c,
  output logic pushout,
  output fp64T r
);

  tripleOperandsT operandsIn;
  tripleOperandsT operandsCap;      // registered operands
  logic           strobeCap;
  mantTripleT     mants;
  fpSidebandT     sidebandDec;      // straight out of decode
  fpSidebandT     sidebandDelayed;  // payload after the delay line
  logic           sidebandStrobe;
  fpSidebandT     sidebandAligned;  // lines up with product
  mantProductT    product;

  assign operandsIn = '{a: a, b: b, c: c};

  pipeDelay #(.payloadT(tripleOperandsT), .DEPTH(`CAPTURE_DEPTH)) capture (
    .clk      (clk),
    .reset    (reset),
    .strobeIn (pushin),
    .dataIn   (operandsIn),
    .strobeOut(strobeCap),
    .dataOut  (operandsCap)
  );

  mulDecode decode (
    .operands(operandsCap),
    .strobe  (strobeCap),
    .mants   (mants),
    .sideband(sidebandDec)
  );

  mantExecute execute (
    .clk    (clk),
    .mants  (mants),
    .product(product)
  );

  pipeDelay #(.payloadT(fpSidebandT), .DEPTH(`SIDEBAND_DEPTH)) sideband (
    .clk      (clk),
    .reset    (reset),
    .strobeIn (sidebandDec.valid),
    .dataIn   (sidebandDec),
    .strobeOut(sidebandStrobe),
    .dataOut  (sidebandDelayed)
  );

  // valid comes from the reset strobe bits, the payload copy is X after reset
  assign sidebandAligned = '{valid: sidebandStrobe, sign: sidebandDelayed.sign,
                             exp: sidebandDelayed.exp, zero: sidebandDelayed.zero};

  roundResult result (
    .clk     (clk),
    .reset   (reset),
    .product (product),
    .sideband(sidebandAligned),
    .pushout (pushout),
    .r       (r)
  );

endmodule

`default_nettype wire

/* sim/tripleMulTb.sv */
/*
  testbench for the triple-product unit, random operands from an LFSR
  expected words come from a 159-bit integer model of the format rules
  operand exponents kept near the bias so results stay in range
  inputs change on the falling edge, outputs are checked there too
*/
`timescale 1ns/100ps
`default_nettype none

`include "tripleMul_consts.svh"

module tripleMulTb
  import fpFormatPkg::*;
;

  localparam int NUM_OPS        = 2000;
  localparam int LATENCY        = 4;
  localparam int TIMEOUT_CYCLES = 4 * NUM_OPS + 100;

  logic clk;
  logic reset;
  logic pushin;
  fp64T a;
  fp64T b;
  fp64T c;
  logic pushout;
  fp64T r;

  logic [31:0] lfsrState = 32'h9432;
  fp64T        expQ [$];    // expected words, oldest first
  int          dueQ [$];    // cycle at which each one must show up
  int          cycle       = 0;  // rising edges so far
  int          opCount     = 0;
  int          resultCount = 0;
  int          runLength   = 0;  // back-to-back pushouts
  int          maxRun      = 0;
  int          leadCount [3] = '{0, 0, 0};  // leading one at 156, 157, 158
  int          carryCount  = 0;  // rounding moved the leading one

  tripleMul uut (
    .clk    (clk),
    .reset  (reset),
    .pushin (pushin),
    .a      (a),
    .b      (b),
    .c      (c),
    .pushout(pushout),
    .r      (r)
  );

  always #10 clk = ~clk;  // 20 ns period

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one LFSR step per bit returned
  function automatic logic [63:0] takeBits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = lfsrNext(lfsrState);
      v = {v[62:0], lfsrState[0]};
    end
    return v;
  endfunction

  function automatic fp64T normalOperand();
    fp64T x;
    int   expOffset;
    x.sign    = (takeBits(1) != 0);
    expOffset = int'(takeBits(10) % 601);                 // 0..600
    x.exp     = 11'(`FP_EXP_BIAS - 300 + expOffset);
    x.fract   = 52'(takeBits(52));
    return x;
  endfunction

  // about one in eight becomes a zero word, sign kept random
  function automatic fp64T randomOperand();
    fp64T x;
    x = normalOperand();
    if (takeBits(3) == 0) begin
      x.exp   = '0;
      x.fract = '0;
    end
    return x;
  endfunction

  function automatic logic isZeroWord(input fp64T x);
    return (x.exp == '0) && (x.fract == '0);
  endfunction

  // reference: exact product, half-lsb rounding, renormalize, pack
  function automatic fp64T modelProduct(input fp64T x, input fp64T y, input fp64T z);
    logic [158:0] ma;
    logic [158:0] mb;
    logic [158:0] mc;
    logic [158:0] p;
    logic [158:0] half;
    logic [158:0] pr;
    int           leadRaw;
    int           leadRnd;
    int           e;
    fp64T         res;
    if (isZeroWord(x) || isZeroWord(y) || isZeroWord(z)) begin
      return '0;  // +0 whatever the signs
    end
    ma = {1'b1, x.fract};
    mb = {1'b1, y.fract};
    mc = {1'b1, z.fract};
    p  = ma * mb * mc;
    leadRaw = p[158] ? 158 : (p[157] ? 157 : 156);
    half = '0;
    half[leadRaw - 53] = 1'b1;  // bit below the last kept fraction bit
    pr = p + half;
    leadRnd = pr[158] ? 158 : (pr[157] ? 157 : 156);
    e = int'(x.exp) + int'(y.exp) + int'(z.exp) - 2 * `FP_EXP_BIAS + 1 + (leadRnd - 157);
    res.sign  = x.sign ^ y.sign ^ z.sign;
    res.exp   = 11'(e);
    res.fract = pr[leadRnd - 1 -: 52];
    leadCount[leadRnd - 156]++;
    if (leadRnd != leadRaw) begin
      carryCount++;
    end
    return res;
  endfunction

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic compareValue(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
    string line;
    if (actual !== expected) begin
      line = $sformatf("Mismatch at %0t: %s is %h, expected %h",
                       $time, name, actual, expected);
      abortRun(line);
    end
  endtask

  // drives one cycle of inputs, queues the expected word on a push
  task automatic applyOp(input logic push, input fp64T x, input fp64T y, input fp64T z);
    @(negedge clk);
    pushin = push;
    a = x;
    b = y;
    c = z;
    if (push) begin
      expQ.push_back(modelProduct(x, y, z));
      dueQ.push_back(cycle + LATENCY);  // four falling edges after the push is driven
      opCount++;
    end
  endtask

  always @(posedge clk) begin
    cycle++;
    if (cycle > TIMEOUT_CYCLES) begin
      abortRun("timeout, the run went past its cycle limit");
    end
  end

  // output monitor, one decision per cycle
  always @(negedge clk) begin
    if (cycle > 0) begin
      if (dueQ.size() > 0 && dueQ[0] == cycle) begin
        compareValue("pushout", 64'(pushout), 64'd1);
        compareValue("r", r, expQ[0]);
        void'(expQ.pop_front());
        void'(dueQ.pop_front());
        resultCount++;
        runLength++;
      end else begin
        compareValue("pushout", 64'(pushout), 64'd0);  // nothing due, nothing out
        if (resultCount == 0) begin
          compareValue("r", r, 64'd0);  // reset value holds until first result
        end
        runLength = 0;
      end
      if (runLength > maxRun) begin
        maxRun = runLength;
      end
    end
  end

  initial begin
    fp64T x;
    fp64T y;
    fp64T z;
    fp64T one;
    fp64T allOnes;
    fp64T tiny;
    logic push;
    int   burstLeft;
    clk       = 1'b0;
    reset     = 1'b1;
    pushin    = 1'b0;
    a         = '0;
    b         = '0;
    c         = '0;
    burstLeft = 0;
    one       = '{sign: 1'b0, exp: 11'(`FP_EXP_BIAS), fract: '0};
    allOnes   = '{sign: 1'b0, exp: 11'(`FP_EXP_BIAS), fract: '1};
    tiny      = '{sign: 1'b0, exp: 11'(`FP_EXP_BIAS), fract: 52'd1};
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // quiet cycles with junk on the operand bus
    repeat (6) applyOp(1'b0, randomOperand(), randomOperand(), randomOperand());

    // all eight sign patterns on normal operands
    for (int s = 0; s < 8; s++) begin
      x = normalOperand();
      y = normalOperand();
      z = normalOperand();
      x.sign = s[0];
      y.sign = s[1];
      z.sign = s[2];
      applyOp(1'b1, x, y, z);
    end

    // one zero operand per op, signs vary
    for (int s = 0; s < 8; s++) begin
      x = normalOperand();
      y = normalOperand();
      z = normalOperand();
      if (s % 3 == 0) x = '{sign: s[0], exp: '0, fract: '0};
      if (s % 3 == 1) y = '{sign: s[1], exp: '0, fract: '0};
      if (s % 3 == 2) z = '{sign: s[2], exp: '0, fract: '0};
      applyOp(1'b1, x, y, z);
    end

    applyOp(1'b1, one, one, one);              // leading one at 156
    applyOp(1'b1, allOnes, allOnes, allOnes);  // leading one at 158
    applyOp(1'b1, allOnes, allOnes, tiny);     // rounding carry 157 -> 158
    applyOp(1'b0, one, one, one);

    // 50 back-to-back pushes
    repeat (50) applyOp(1'b1, randomOperand(), randomOperand(), randomOperand());

    while (opCount < NUM_OPS) begin
      if (burstLeft > 0) begin
        push = 1'b1;
        burstLeft--;
      end else if (takeBits(4) == 0) begin
        burstLeft = int'(takeBits(4));  // start of a burst
        push = 1'b1;
      end else begin
        push = (takeBits(2) != 0);
      end
      applyOp(push, randomOperand(), randomOperand(), randomOperand());
    end

    // drain, then a few idle cycles to catch stray pushouts
    applyOp(1'b0, one, one, one);
    while (dueQ.size() > 0) begin
      @(negedge clk);
    end
    repeat (8) @(negedge clk);

    if (resultCount == NUM_OPS && maxRun >= 50 && carryCount > 0 &&
        leadCount[0] > 0 && leadCount[1] > 0 && leadCount[2] > 0) begin
      $display("Test OK");
      $finish;
    end else begin
      abortRun($sformatf("incomplete run, %0d results, longest run %0d, carries %0d",
                         resultCount, maxRun, carryCount));
    end
  end

endmodule

`default_nettype wire

/* tripleMul.f */
+incdir+source
source/fpFormatPkg.sv
source/mulPipePkg.sv
source/pipeDelay.sv
source/mulDecode.sv
source/mantExecute.sv
source/roundResult.sv
source/tripleMul.sv
sim/tripleMulTb.sv

/* Bender.yml */
package:
  name: tripleMul

sources:
  - include_dirs:
      - source
    files:
      - source/fpFormatPkg.sv
      - source/mulPipePkg.sv
      - source/pipeDelay.sv
      - source/mulDecode.sv
      - source/mantExecute.sv
      - source/roundResult.sv
      - source/tripleMul.sv
  - target: test
    include_dirs:
      - source
    files:
      - sim/tripleMulTb.sv
